// ==== logic/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_index_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  func_t;
	typedef logic [4:0]  shamt_t;

	localparam int NUM_REGS = 32;

	// Primary opcodes
	localparam opcode_t RTYPE  = 6'b000000;
	localparam opcode_t REGIMM = 6'b000001;
	localparam opcode_t J      = 6'b000010;
	localparam opcode_t JAL    = 6'b000011;
	localparam opcode_t BEQ    = 6'b000100;
	localparam opcode_t BNE    = 6'b000101;
	localparam opcode_t BLEZ   = 6'b000110;
	localparam opcode_t BGTZ   = 6'b000111;
	localparam opcode_t ADDI   = 6'b001000;
	localparam opcode_t ADDIU  = 6'b001001;
	localparam opcode_t SLTI   = 6'b001010;
	localparam opcode_t SLTIU  = 6'b001011;
	localparam opcode_t ORI    = 6'b001101;
	localparam opcode_t XORI   = 6'b001110;
	localparam opcode_t LUI    = 6'b001111;
	localparam opcode_t MUL_OP = 6'b011100; // SPECIAL2
	localparam opcode_t LB     = 6'b100000;
	localparam opcode_t LW     = 6'b100011;
	localparam opcode_t LBU    = 6'b100100;
	localparam opcode_t SB     = 6'b101000;
	localparam opcode_t SW     = 6'b101011;

	// R-type function field
	localparam func_t SLL      = 6'b000000;
	localparam func_t SRL      = 6'b000010;
	localparam func_t SRA      = 6'b000011;
	localparam func_t SLLV     = 6'b000100;
	localparam func_t SRLV     = 6'b000110;
	localparam func_t SRAV     = 6'b000111;
	localparam func_t JR       = 6'b001000;
	localparam func_t JALR     = 6'b001001;
	localparam func_t MFHI     = 6'b010000;
	localparam func_t MFLO     = 6'b010010;
	localparam func_t MULT     = 6'b011000;
	localparam func_t MULTU    = 6'b011001;
	localparam func_t DIV      = 6'b011010;
	localparam func_t DIVU     = 6'b011011;
	localparam func_t ADD      = 6'b100000;
	localparam func_t ADDU     = 6'b100001;
	localparam func_t SUB      = 6'b100010;
	localparam func_t SUBU     = 6'b100011;
	localparam func_t AND      = 6'b100100;
	localparam func_t OR       = 6'b100101;
	localparam func_t XOR      = 6'b100110;
	localparam func_t NOR      = 6'b100111;
	localparam func_t SLT      = 6'b101010;
	localparam func_t SLTU     = 6'b101011;
	localparam func_t MUL_FUNC = 6'b000010; // Only under MUL_OP

	// REGIMM branches selected by rt
	localparam reg_index_t RT_BLTZ = 5'b00000;
	localparam reg_index_t RT_BGEZ = 5'b00001;

	// NOP is zero so reset lands on it
	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_ILLEGAL,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		OP_MFHI, OP_MFLO,
		OP_SLT, OP_SLTU,
		OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_JALR, OP_JR,
		OP_MUL,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI,
		OP_LW, OP_SW, OP_LB, OP_LBU, OP_SB,
		OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
		OP_BLTZ, OP_BGEZ,
		OP_J, OP_JAL
	} alu_op_t;

endpackage

`default_nettype wire

// ==== logic/decoded_insn_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decoded_insn_if;
	import decode_pkg::*;

	opcode_t    opcode;
	reg_index_t rs;
	reg_index_t rt;
	reg_index_t rd;
	shamt_t     sa;
	func_t      func;
	alu_op_t    alu_op;
	word_t      imm_sx;
	reg_index_t dest; // Write-back target

	modport source (
		output opcode, rs, rt, rd, sa, func, alu_op, imm_sx, dest
	);

	modport sink (
		input opcode, rs, rt, rd, sa, func, alu_op, imm_sx, dest
	);

endinterface

`default_nettype wire

// ==== logic/insn_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module insn_decoder (
	input decode_pkg::word_t insn,
	decoded_insn_if.source decoded
);
	import decode_pkg::*;

	opcode_t    op_field;
	reg_index_t rs_field;
	reg_index_t rt_field;
	reg_index_t rd_field;
	shamt_t     sa_field;
	func_t      func_field;
	alu_op_t    r_op;
	alu_op_t    i_op;

	function automatic alu_op_t rtype_op(input func_t f);
		case (f)
			ADD: return OP_ADD;
			ADDU: return OP_ADDU;
			SUB: return OP_SUB;
			SUBU: return OP_SUBU;
			MULT: return OP_MULT;
			MULTU: return OP_MULTU;
			DIV: return OP_DIV;
			DIVU: return OP_DIVU;
			MFHI: return OP_MFHI;
			MFLO: return OP_MFLO;
			SLT: return OP_SLT;
			SLTU: return OP_SLTU;
			SLL: return OP_SLL;
			SLLV: return OP_SLLV;
			SRL: return OP_SRL;
			SRLV: return OP_SRLV;
			SRA: return OP_SRA;
			SRAV: return OP_SRAV;
			AND: return OP_AND;
			OR: return OP_OR;
			XOR: return OP_XOR;
			NOR: return OP_NOR;
			JALR: return OP_JALR;
			JR: return OP_JR;
			default: return OP_ILLEGAL;
		endcase
	endfunction

	function automatic alu_op_t itype_op(input opcode_t op);
		case (op)
			ADDI: return OP_ADDI;
			ADDIU: return OP_ADDIU;
			SLTI: return OP_SLTI;
			SLTIU: return OP_SLTIU;
			ORI: return OP_ORI;
			XORI: return OP_XORI;
			LUI: return OP_LUI;
			LW: return OP_LW;
			SW: return OP_SW;
			LB: return OP_LB;
			LBU: return OP_LBU;
			SB: return OP_SB;
			BEQ: return OP_BEQ;
			BNE: return OP_BNE;
			BGTZ: return OP_BGTZ;
			BLEZ: return OP_BLEZ;
			default: return OP_ILLEGAL;
		endcase
	endfunction

	assign op_field   = insn[31:26];
	assign rs_field   = insn[25:21];
	assign rt_field   = insn[20:16];
	assign rd_field   = insn[15:11];
	assign sa_field   = insn[10:6];
	assign func_field = insn[5:0];

	assign r_op = rtype_op(func_field);
	assign i_op = itype_op(op_field);

	always_comb begin
		decoded.opcode = '0; // Unknown words leave every field zero
		decoded.rs = '0;
		decoded.rt = '0;
		decoded.rd = '0;
		decoded.sa = '0;
		decoded.func = '0;
		decoded.alu_op = OP_ILLEGAL;
		decoded.imm_sx = '0;
		decoded.dest = '0;

		if (insn == '0) begin
			decoded.alu_op = OP_NOP;
		end else begin
			case (op_field)
				RTYPE: begin
					if (r_op != OP_ILLEGAL) begin
						decoded.opcode = RTYPE;
						decoded.rs = rs_field;
						decoded.rt = rt_field;
						decoded.rd = rd_field;
						decoded.func = func_field;
						decoded.alu_op = r_op;
						decoded.dest = rd_field;
						case (r_op)
							OP_SLL, OP_SRL, OP_SRA: begin
								decoded.sa = sa_field; // Shift by constant
								decoded.rs = '0;
							end
							OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: begin
								decoded.rd = '0; // Result goes to HI/LO
								decoded.dest = '0;
							end
							OP_MFHI, OP_MFLO: begin
								decoded.rs = '0;
								decoded.rt = '0;
							end
							OP_JR: begin
								decoded.rt = '0;
								decoded.rd = '0;
								decoded.dest = '0;
							end
							default: begin
							end
						endcase
					end
				end
				MUL_OP: begin
					if (func_field == MUL_FUNC) begin
						decoded.opcode = MUL_OP;
						decoded.rs = rs_field;
						decoded.rt = rt_field;
						decoded.rd = rd_field;
						decoded.func = func_field;
						decoded.alu_op = OP_MUL;
						decoded.dest = rd_field;
					end
				end
				REGIMM: begin
					if (rt_field == RT_BLTZ || rt_field == RT_BGEZ) begin
						decoded.opcode = REGIMM;
						decoded.rs = rs_field;
						decoded.rt = rt_field;
						decoded.alu_op = (rt_field == RT_BLTZ) ? OP_BLTZ : OP_BGEZ;
						decoded.imm_sx = {{16{insn[15]}}, insn[15:0]};
						decoded.dest = rt_field;
					end
				end
				J, JAL: begin
					decoded.opcode = op_field;
					decoded.alu_op = (op_field == J) ? OP_J : OP_JAL;
					decoded.imm_sx = {6'b0, insn[25:0]}; // Jump target
				end
				default: begin
					if (i_op != OP_ILLEGAL) begin
						decoded.opcode = op_field;
						decoded.rs = (i_op == OP_LUI) ? '0 : rs_field;
						decoded.rt = rt_field;
						decoded.alu_op = i_op;
						decoded.imm_sx = {{16{insn[15]}}, insn[15:0]};
						decoded.dest = rt_field;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/decode_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_register (
	input  logic clock,
	input  logic reset,
	input  logic enable_decode,
	input  decode_pkg::word_t pc,
	input  decode_pkg::word_t insn,
	decoded_insn_if.sink next,
	decoded_insn_if.source held,
	output decode_pkg::word_t pc_out,
	output decode_pkg::word_t insn_out
);
	import decode_pkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			held.opcode <= '0; // Held state is a clean NOP
			held.rs <= '0;
			held.rt <= '0;
			held.rd <= '0;
			held.sa <= '0;
			held.func <= '0;
			held.alu_op <= OP_NOP;
			held.imm_sx <= '0;
			held.dest <= '0;
			pc_out <= '0;
			insn_out <= '0;
		end else if (enable_decode) begin
			held.opcode <= next.opcode;
			held.rs <= next.rs;
			held.rt <= next.rt;
			held.rd <= next.rd;
			held.sa <= next.sa;
			held.func <= next.func;
			held.alu_op <= next.alu_op;
			held.imm_sx <= next.imm_sx;
			held.dest <= next.dest;
			pc_out <= pc;
			insn_out <= insn;
		end
	end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
	input  logic clock,
	input  logic reset,
	decoded_insn_if.sink held,
	input  logic write_enable,
	input  decode_pkg::word_t write_data,
	output decode_pkg::word_t rs_value,
	output decode_pkg::word_t rt_value
);
	import decode_pkg::*;

	word_t regs [NUM_REGS];

	// Operands of the held instruction
	assign rs_value = regs[held.rs];
	assign rt_value = regs[held.rt];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= word_t'(i); // Register i starts at i
			end
		end else if (write_enable && held.dest != '0) begin
			regs[held.dest] <= write_data; // r0 stays zero
		end
	end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic enable_decode,
	input  decode_pkg::word_t insn,
	input  decode_pkg::word_t pc,
	input  logic write_enable,
	input  decode_pkg::word_t write_data,
	output decode_pkg::opcode_t opcode,
	output decode_pkg::reg_index_t rs,
	output decode_pkg::reg_index_t rt,
	output decode_pkg::reg_index_t rd,
	output decode_pkg::shamt_t sa,
	output decode_pkg::func_t func,
	output decode_pkg::alu_op_t alu_op,
	output decode_pkg::word_t imm_sx,
	output decode_pkg::word_t pc_out,
	output decode_pkg::word_t insn_out,
	output decode_pkg::word_t rs_value,
	output decode_pkg::word_t rt_value
);

	decoded_insn_if next_insn ();
	decoded_insn_if held_insn ();

	insn_decoder insn_decoder_inst (
		.insn    (insn),
		.decoded (next_insn.source)
	);

	decode_register decode_register_inst (
		.clock         (clock),
		.reset         (reset),
		.enable_decode (enable_decode),
		.pc            (pc),
		.insn          (insn),
		.next          (next_insn.sink),
		.held          (held_insn.source),
		.pc_out        (pc_out),
		.insn_out      (insn_out)
	);

	register_file register_file_inst (
		.clock        (clock),
		.reset        (reset),
		.held         (held_insn.sink),
		.write_enable (write_enable),
		.write_data   (write_data),
		.rs_value     (rs_value),
		.rt_value     (rt_value)
	);

	// Held fields out to the next stage
	assign opcode = held_insn.opcode;
	assign rs     = held_insn.rs;
	assign rt     = held_insn.rt;
	assign rd     = held_insn.rd;
	assign sa     = held_insn.sa;
	assign func   = held_insn.func;
	assign alu_op = held_insn.alu_op;
	assign imm_sx = held_insn.imm_sx;

endmodule

`default_nettype wire

// ==== include/decode_tb_tasks.svh ====
`ifndef DECODE_TB_TASKS_SVH
`define DECODE_TB_TASKS_SVH

typedef struct packed {
	opcode_t    opcode;
	reg_index_t rs;
	reg_index_t rt;
	reg_index_t rd;
	shamt_t     sa;
	func_t      func;
	alu_op_t    alu_op;
	word_t      imm_sx;
} expect_t;

function automatic expect_t blank_expect(input alu_op_t a);
	expect_t e;
	e = '0;
	e.alu_op = a;
	return e;
endfunction

function automatic expect_t make_rtype(input opcode_t op, input func_t f, input alu_op_t a,
		input reg_index_t rd_sel, output word_t w);
	expect_t e;
	e = blank_expect(a);
	e.opcode = op;
	e.func = f;
	e.rs = reg_index_t'(rand_bits(5));
	e.rt = reg_index_t'(rand_bits(5));
	e.rd = rd_sel;
	e.sa = shamt_t'(rand_bits(5));
	w = {op, e.rs, e.rt, e.rd, e.sa, f};
	if (a == OP_SLL || a == OP_SRL || a == OP_SRA) begin
		e.rs = '0; // Constant shifts keep sa only
	end else begin
		e.sa = '0;
	end
	if (a == OP_MULT || a == OP_MULTU || a == OP_DIV || a == OP_DIVU) begin
		e.rd = '0;
	end
	if (a == OP_MFHI || a == OP_MFLO) begin
		e.rs = '0;
		e.rt = '0;
	end
	if (a == OP_JR) begin
		e.rt = '0;
		e.rd = '0;
	end
	return e;
endfunction

function automatic expect_t make_itype(input opcode_t op, input alu_op_t a,
		input reg_index_t rs_sel, input reg_index_t rt_sel, input logic negative,
		output word_t w);
	expect_t e;
	logic [15:0] imm;
	imm = 16'(rand_bits(16));
	imm[15] = negative;
	e = blank_expect(a);
	e.opcode = op;
	e.rs = (a == OP_LUI) ? '0 : rs_sel;
	e.rt = rt_sel;
	e.imm_sx = {{16{imm[15]}}, imm};
	w = {op, rs_sel, rt_sel, imm};
	return e;
endfunction

function automatic expect_t make_jump(input opcode_t op, input alu_op_t a, output word_t w);
	expect_t e;
	logic [25:0] target;
	target = 26'(rand_bits(26));
	e = blank_expect(a);
	e.opcode = op;
	e.imm_sx = {6'b0, target}; // Zero-extended target
	w = {op, target};
	return e;
endfunction

function automatic reg_index_t rand_nonzero_reg();
	reg_index_t r;
	r = reg_index_t'(rand_bits(5));
	return (r == '0) ? 5'd1 : r;
endfunction

task automatic decode_one(input word_t w, input word_t p);
	@(posedge clock);
	insn <= w;
	pc <= p;
	enable_decode <= 1'b1;
	@(posedge clock);
	enable_decode <= 1'b0;
	@(negedge clock);
endtask

task automatic write_one(input word_t value);
	@(posedge clock);
	write_enable <= 1'b1;
	write_data <= value;
	@(posedge clock);
	write_enable <= 1'b0;
	@(negedge clock);
endtask

task automatic check_word(input string name, input string field, input word_t expected,
		input word_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
	end
endtask

task automatic check_index(input string name, input string field, input reg_index_t expected,
		input reg_index_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s %s: expected %0d, actual %0d", name, field, expected, actual);
	end
endtask

task automatic check_func(input string name, input string field, input func_t expected,
		input func_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s %s: expected %b, actual %b", name, field, expected, actual);
	end
endtask

task automatic check_op(input string name, input alu_op_t expected, input alu_op_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s alu_op: expected %s, actual %s", name, expected.name(),
			actual.name());
	end
endtask

task automatic check_outputs(input string name, input expect_t e, input word_t w,
		input word_t p);
	check_func(name, "opcode", e.opcode, opcode);
	check_index(name, "rs", e.rs, rs);
	check_index(name, "rt", e.rt, rt);
	check_index(name, "rd", e.rd, rd);
	check_index(name, "sa", e.sa, sa);
	check_func(name, "func", e.func, func);
	check_op(name, e.alu_op, alu_op);
	check_word(name, "imm_sx", e.imm_sx, imm_sx);
	check_word(name, "pc_out", p, pc_out);
	check_word(name, "insn_out", w, insn_out);
	check_word(name, "rs_value", reg_model[e.rs], rs_value);
	check_word(name, "rt_value", reg_model[e.rt], rt_value);
endtask

task automatic decode_and_check(input string name, input expect_t e, input word_t w);
	word_t p;
	p = rand_bits(32);
	decode_one(w, p);
	check_outputs(name, e, w, p);
endtask

task automatic report_test(input string name, input int errors_before);
	test_count++;
	if (error_count == errors_before) begin
		$display("%s: passed", name);
	end else begin
		$display("%s: %0d mismatches", name, error_count - errors_before);
	end
endtask

task automatic reset_test();
	int errors_before;
	errors_before = error_count;
	check_outputs("reset", blank_expect(OP_NOP), '0, '0);
	report_test("reset", errors_before);
endtask

task automatic rtype_test();
	func_t funcs [24] = '{ADD, ADDU, SUB, SUBU, MULT, MULTU, DIV, DIVU, MFHI, MFLO,
		SLT, SLTU, SLL, SLLV, SRL, SRLV, SRA, SRAV, AND, OR, XOR, NOR, JALR, JR};
	alu_op_t ops [24] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_MULT, OP_MULTU, OP_DIV,
		OP_DIVU, OP_MFHI, OP_MFLO, OP_SLT, OP_SLTU, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV,
		OP_SRA, OP_SRAV, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_JALR, OP_JR};
	int errors_before;
	expect_t e;
	word_t w;
	errors_before = error_count;
	for (int i = 0; i < 24; i++) begin
		e = make_rtype(RTYPE, funcs[i], ops[i], rand_nonzero_reg(), w); // rd never zero
		decode_and_check("rtype", e, w);
	end
	e = make_rtype(MUL_OP, MUL_FUNC, OP_MUL, rand_nonzero_reg(), w);
	decode_and_check("rtype", e, w);
	report_test("rtype", errors_before);
endtask

task automatic itype_test();
	opcode_t opcodes [16] = '{ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LUI, LW, SW, LB, LBU, SB,
		BEQ, BNE, BGTZ, BLEZ};
	alu_op_t ops [16] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI,
		OP_LW, OP_SW, OP_LB, OP_LBU, OP_SB, OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ};
	int errors_before;
	expect_t e;
	word_t w;
	errors_before = error_count;
	for (int i = 0; i < 16; i++) begin
		e = make_itype(opcodes[i], ops[i], reg_index_t'(rand_bits(5)),
			reg_index_t'(rand_bits(5)), i[0], w); // Odd entries negative
		decode_and_check("itype", e, w);
	end
	e = make_itype(REGIMM, OP_BLTZ, reg_index_t'(rand_bits(5)), RT_BLTZ, 1'b1, w);
	decode_and_check("itype", e, w);
	e = make_itype(REGIMM, OP_BGEZ, reg_index_t'(rand_bits(5)), RT_BGEZ, 1'b0, w);
	decode_and_check("itype", e, w);
	report_test("itype", errors_before);
endtask

task automatic jump_nop_illegal_test();
	int errors_before;
	expect_t e;
	word_t w;
	word_t bad [4];
	errors_before = error_count;
	e = make_jump(J, OP_J, w);
	decode_and_check("jump_nop_illegal", e, w);
	e = make_jump(JAL, OP_JAL, w);
	decode_and_check("jump_nop_illegal", e, w);
	decode_and_check("jump_nop_illegal", blank_expect(OP_NOP), '0);
	for (int i = 0; i < 4; i++) begin
		bad[i] = rand_bits(32);
	end
	bad[0][31:26] = 6'b111111; // Unassigned opcode
	bad[1][31:26] = RTYPE;
	bad[1][5:0] = 6'b000001;
	bad[2][31:26] = MUL_OP;
	bad[2][5:0] = ADD;
	bad[3][31:26] = REGIMM;
	bad[3][20:16] = 5'b00010;
	for (int i = 0; i < 4; i++) begin
		decode_and_check("jump_nop_illegal", blank_expect(OP_ILLEGAL), bad[i]);
	end
	report_test("jump_nop_illegal", errors_before);
endtask

task automatic hold_test();
	int errors_before;
	expect_t e;
	word_t w;
	word_t p;
	errors_before = error_count;
	e = make_itype(ADDI, OP_ADDI, reg_index_t'(rand_bits(5)), reg_index_t'(rand_bits(5)),
		1'b1, w);
	p = rand_bits(32);
	decode_one(w, p);
	repeat (5) begin
		@(posedge clock);
		insn <= rand_bits(32); // Enable stays low
		pc <= rand_bits(32);
	end
	@(negedge clock);
	check_outputs("hold", e, w, p);
	report_test("hold", errors_before);
endtask

task automatic writeback_test();
	int errors_before;
	expect_t e;
	word_t w;
	word_t value;
	reg_index_t target;
	errors_before = error_count;
	target = rand_nonzero_reg();
	e = make_rtype(RTYPE, ADD, OP_ADD, target, w);
	decode_and_check("writeback", e, w);
	value = rand_bits(32);
	write_one(value);
	reg_model[target] = value;
	e = make_itype(ADDI, OP_ADDI, target, reg_index_t'(rand_bits(5)), 1'b0, w);
	decode_and_check("writeback", e, w);
	e = make_jump(J, OP_J, w); // Held dest is zero
	decode_and_check("writeback", e, w);
	write_one(rand_bits(32));
	check_word("writeback", "r0", '0, rs_value);
	report_test("writeback", errors_before);
endtask

`endif

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;
	import decode_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	localparam int DECODE_COUNT = 54; // Two-cycle decodes over all tests
	localparam int TEST_CYCLES = RESET_CYCLES + DECODE_COUNT * 2 + 5 + 2 * 2;
	localparam int MARGIN_CYCLES = 50;
	localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD;

	logic clock = 1'b0;
	logic reset;
	logic enable_decode;
	word_t insn;
	word_t pc;
	logic write_enable;
	word_t write_data;
	opcode_t opcode;
	reg_index_t rs;
	reg_index_t rt;
	reg_index_t rd;
	shamt_t sa;
	func_t func;
	alu_op_t alu_op;
	word_t imm_sx;
	word_t pc_out;
	word_t insn_out;
	word_t rs_value;
	word_t rt_value;

	word_t reg_model [NUM_REGS]; // Expected register contents
	logic [31:0] lfsr = 32'h3b5fabf2;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	decode_stage decode_stage_inst (
		.clock         (clock),
		.reset         (reset),
		.enable_decode (enable_decode),
		.insn          (insn),
		.pc            (pc),
		.write_enable  (write_enable),
		.write_data    (write_data),
		.opcode        (opcode),
		.rs            (rs),
		.rt            (rt),
		.rd            (rd),
		.sa            (sa),
		.func          (func),
		.alu_op        (alu_op),
		.imm_sx        (imm_sx),
		.pc_out        (pc_out),
		.insn_out      (insn_out),
		.rs_value      (rs_value),
		.rt_value      (rt_value)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	`include "decode_tb_tasks.svh"

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset = 1'b1;
		enable_decode = 1'b0;
		insn = '0;
		pc = '0;
		write_enable = 1'b0;
		write_data = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			reg_model[i] = word_t'(i);
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		reset_test();
		rtype_test();
		itype_test();
		jump_nop_illegal_test();
		hold_test();
		writeback_test();
		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
logic/decode_pkg.sv
logic/decoded_insn_if.sv
logic/insn_decoder.sv
logic/decode_register.sv
logic/register_file.sv
logic/decode_stage.sv
bench/decode_stage_tb.sv
